//--- design/cfg_bus_pkg.sv
`default_nettype none

package cfg_bus_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  // Register offset inside one 4 KiB region
  localparam int unsigned OFS_WIDTH = 12;

  // Address map
  localparam logic [ADDR_WIDTH-1:0] H2C_MBOX_BASE = 32'h1040_2000;
  localparam logic [ADDR_WIDTH-1:0] C2H_MBOX_BASE = 32'h1040_3000;
  localparam logic [ADDR_WIDTH-1:0] DOORBELL_BASE = 32'h1040_4000;
  localparam logic [ADDR_WIDTH-1:0] REGION_SIZE   = 32'h0000_1000;

  // Mailbox registers
  localparam logic [OFS_WIDTH-1:0] MBOX_DATA_OFS   = 12'h000;
  localparam logic [OFS_WIDTH-1:0] MBOX_STATUS_OFS = 12'h004;
  localparam logic [OFS_WIDTH-1:0] MBOX_THRESH_OFS = 12'h008;
  localparam logic [OFS_WIDTH-1:0] MBOX_IRQEN_OFS  = 12'h00C;

  // Doorbell block registers
  localparam logic [OFS_WIDTH-1:0] DB_DOORBELL_OFS   = 12'h000;
  localparam logic [OFS_WIDTH-1:0] DB_COMPLETION_OFS = 12'h004;
  localparam logic [OFS_WIDTH-1:0] DB_CLEAR_OFS      = 12'h008;

  typedef enum logic [1:0] {
    TGT_H2C  = 2'd0,
    TGT_C2H  = 2'd1,
    TGT_DB   = 2'd2,
    TGT_NONE = 2'd3
  } tgt_sel_e;

endpackage

`default_nettype wire

//--- design/cfg_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_bus_arbiter import cfg_bus_pkg::*; (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire logic                  host_req_valid_i,
  input  wire logic                  host_req_write_i,
  input  wire logic [ADDR_WIDTH-1:0] host_req_addr_i,
  input  wire logic [DATA_WIDTH-1:0] host_req_wdata_i,
  output logic                       host_req_ready_o,
  output logic                       host_resp_valid_o,
  output logic      [DATA_WIDTH-1:0] host_resp_rdata_o,
  output logic                       host_resp_err_o,
  input  wire logic                  cluster_req_valid_i,
  input  wire logic                  cluster_req_write_i,
  input  wire logic [ADDR_WIDTH-1:0] cluster_req_addr_i,
  input  wire logic [DATA_WIDTH-1:0] cluster_req_wdata_i,
  output logic                       cluster_req_ready_o,
  output logic                       cluster_resp_valid_o,
  output logic      [DATA_WIDTH-1:0] cluster_resp_rdata_o,
  output logic                       cluster_resp_err_o,
  output logic                       acc_valid_o,
  output logic                       acc_write_o,
  output logic      [ADDR_WIDTH-1:0] acc_addr_o,
  output logic      [DATA_WIDTH-1:0] acc_wdata_o,
  input  wire logic                  rsp_valid_i,
  input  wire logic [DATA_WIDTH-1:0] rsp_rdata_i,
  input  wire logic                  rsp_err_i
);

  // owner_q and last_grant_q: 1 means cluster
  logic grant_q;
  logic busy_q;
  logic owner_q;
  logic last_grant_q;
  logic pick_cluster;

  // Host wins a tie unless it was granted last
  assign pick_cluster = cluster_req_valid_i && (!host_req_valid_i || !last_grant_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      grant_q      <= 1'b0;
      busy_q       <= 1'b0;
      owner_q      <= 1'b0;
      last_grant_q <= 1'b1;
    end else if (grant_q) begin
      grant_q <= 1'b0;
      busy_q  <= 1'b1;
    end else if (busy_q) begin
      if (rsp_valid_i) begin
        busy_q <= 1'b0;
      end
    end else if (host_req_valid_i || cluster_req_valid_i) begin
      grant_q      <= 1'b1;
      owner_q      <= pick_cluster;
      last_grant_q <= pick_cluster;
    end
  end

  assign host_req_ready_o    = grant_q && !owner_q;
  assign cluster_req_ready_o = grant_q && owner_q;

  assign acc_valid_o = grant_q;
  assign acc_write_o = owner_q ? cluster_req_write_i : host_req_write_i;
  assign acc_addr_o  = owner_q ? cluster_req_addr_i  : host_req_addr_i;
  assign acc_wdata_o = owner_q ? cluster_req_wdata_i : host_req_wdata_i;

  // Response goes back to the owner only
  assign host_resp_valid_o    = busy_q && rsp_valid_i && !owner_q;
  assign cluster_resp_valid_o = busy_q && rsp_valid_i && owner_q;
  assign host_resp_rdata_o    = owner_q ? '0 : rsp_rdata_i;
  assign cluster_resp_rdata_o = owner_q ? rsp_rdata_i : '0;
  assign host_resp_err_o      = !owner_q && rsp_err_i;
  assign cluster_resp_err_o   = owner_q && rsp_err_i;

endmodule

`default_nettype wire

//--- design/cfg_addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_addr_decoder import cfg_bus_pkg::*; (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire logic                  acc_valid_i,
  input  wire logic                  acc_write_i,
  input  wire logic [ADDR_WIDTH-1:0] acc_addr_i,
  input  wire logic [DATA_WIDTH-1:0] acc_wdata_i,
  output logic                       h2c_sel_o,
  output logic                       c2h_sel_o,
  output logic                       db_sel_o,
  output logic                       tgt_write_o,
  output logic       [OFS_WIDTH-1:0] tgt_offset_o,
  output logic      [DATA_WIDTH-1:0] tgt_wdata_o,
  input  wire logic [DATA_WIDTH-1:0] h2c_rdata_i,
  input  wire logic                  h2c_err_i,
  input  wire logic [DATA_WIDTH-1:0] c2h_rdata_i,
  input  wire logic                  c2h_err_i,
  input  wire logic [DATA_WIDTH-1:0] db_rdata_i,
  input  wire logic                  db_err_i,
  output logic                       rsp_valid_o,
  output logic      [DATA_WIDTH-1:0] rsp_rdata_o,
  output logic                       rsp_err_o
);

  tgt_sel_e tgt_sel_d;
  tgt_sel_e tgt_sel_q;
  logic     valid_q;

  function automatic logic in_region(logic [ADDR_WIDTH-1:0] addr, logic [ADDR_WIDTH-1:0] base);
    return (addr >= base) && (addr < base + REGION_SIZE);
  endfunction

  always_comb begin
    if (in_region(acc_addr_i, H2C_MBOX_BASE)) tgt_sel_d = TGT_H2C;
    else if (in_region(acc_addr_i, C2H_MBOX_BASE)) tgt_sel_d = TGT_C2H;
    else if (in_region(acc_addr_i, DOORBELL_BASE)) tgt_sel_d = TGT_DB;
    else tgt_sel_d = TGT_NONE;
  end

  assign h2c_sel_o    = acc_valid_i && (tgt_sel_d == TGT_H2C);
  assign c2h_sel_o    = acc_valid_i && (tgt_sel_d == TGT_C2H);
  assign db_sel_o     = acc_valid_i && (tgt_sel_d == TGT_DB);
  assign tgt_write_o  = acc_write_i;
  assign tgt_offset_o = acc_addr_i[OFS_WIDTH-1:0];
  assign tgt_wdata_o  = acc_wdata_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q   <= 1'b0;
      tgt_sel_q <= TGT_NONE;
    end else begin
      valid_q <= acc_valid_i;
      if (acc_valid_i) tgt_sel_q <= tgt_sel_d;
    end
  end

  // Unmapped accesses answer with zero data and err
  always_comb begin
    rsp_rdata_o = '0;
    rsp_err_o   = 1'b1;
    case (tgt_sel_q)
      TGT_H2C: begin
        rsp_rdata_o = h2c_rdata_i;
        rsp_err_o   = h2c_err_i;
      end
      TGT_C2H: begin
        rsp_rdata_o = c2h_rdata_i;
        rsp_err_o   = c2h_err_i;
      end
      TGT_DB: begin
        rsp_rdata_o = db_rdata_i;
        rsp_err_o   = db_err_i;
      end
      default: ;
    endcase
  end

  assign rsp_valid_o = valid_q;

endmodule

`default_nettype wire

//--- design/msg_mailbox.sv
`timescale 1ns/1ps
`default_nettype none

module msg_mailbox import cfg_bus_pkg::*; #(
  parameter int unsigned MBOX_DEPTH = 8
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire logic                  sel_i,
  input  wire logic                  write_i,
  input  wire logic  [OFS_WIDTH-1:0] offset_i,
  input  wire logic [DATA_WIDTH-1:0] wdata_i,
  output logic      [DATA_WIDTH-1:0] rdata_o,
  output logic                       err_o,
  output logic                       irq_o
);

  localparam int unsigned PTR_W = $clog2(MBOX_DEPTH);
  localparam int unsigned CNT_W = PTR_W + 1;

  logic [DATA_WIDTH-1:0] mem_q [MBOX_DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      count_q;
  logic [DATA_WIDTH-1:0] thresh_q;
  logic                  irq_en_q;
  logic [DATA_WIDTH-1:0] rdata_q;
  logic                  err_q;
  logic [DATA_WIDTH-1:0] status;
  logic                  empty;
  logic                  full;
  logic                  data_acc;
  logic                  push;
  logic                  pop;

  assign empty    = (count_q == '0);
  assign full     = (count_q == CNT_W'(MBOX_DEPTH));
  assign data_acc = sel_i && (offset_i == MBOX_DATA_OFS);
  assign push     = data_acc && write_i && !full;
  assign pop      = data_acc && !write_i && !empty;

  always_comb begin
    status            = '0;
    status[0]         = empty;
    status[1]         = full;
    status[8 +: CNT_W] = count_q;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      thresh_q <= '0;
      irq_en_q <= 1'b0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push) count_q <= count_q + 1'b1;
      else if (pop) count_q <= count_q - 1'b1;
      if (sel_i && write_i && offset_i == MBOX_THRESH_OFS) thresh_q <= wdata_i;
      if (sel_i && write_i && offset_i == MBOX_IRQEN_OFS) irq_en_q <= wdata_i[0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= wdata_i;
  end

  // Read data and error for the current access
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_q <= '0;
      err_q   <= 1'b0;
      case (offset_i)
        MBOX_DATA_OFS: begin
          if (write_i) err_q <= full;
          else if (empty) err_q <= 1'b1;
          else rdata_q <= mem_q[rd_ptr_q];
        end
        MBOX_STATUS_OFS: if (!write_i) rdata_q <= status;
        MBOX_THRESH_OFS: if (!write_i) rdata_q <= thresh_q;
        MBOX_IRQEN_OFS:  if (!write_i) rdata_q <= {{(DATA_WIDTH-1){1'b0}}, irq_en_q};
        default:         err_q <= 1'b1;
      endcase
    end
  end

  assign rdata_o = rdata_q;
  assign err_o   = err_q;

  // Level interrupt above threshold
  assign irq_o = irq_en_q && (DATA_WIDTH'(count_q) > thresh_q);

endmodule

`default_nettype wire

//--- design/doorbell_regs.sv
`timescale 1ns/1ps
`default_nettype none

module doorbell_regs import cfg_bus_pkg::*; (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire logic                  sel_i,
  input  wire logic                  write_i,
  input  wire logic  [OFS_WIDTH-1:0] offset_i,
  input  wire logic [DATA_WIDTH-1:0] wdata_i,
  output logic      [DATA_WIDTH-1:0] rdata_o,
  output logic                       err_o,
  output logic                       doorbell_irq_o,
  output logic                       completion_irq_o
);

  logic                  doorbell_q;
  logic                  completion_q;
  logic [DATA_WIDTH-1:0] rdata_q;
  logic                  err_q;
  logic                  wr;

  assign wr = sel_i && write_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      doorbell_q   <= 1'b0;
      completion_q <= 1'b0;
    end else begin
      if (wr && offset_i == DB_DOORBELL_OFS && wdata_i[0]) doorbell_q <= 1'b1;
      else if (wr && offset_i == DB_CLEAR_OFS && wdata_i[0]) doorbell_q <= 1'b0;
      if (wr && offset_i == DB_COMPLETION_OFS && wdata_i[0]) completion_q <= 1'b1;
      else if (wr && offset_i == DB_CLEAR_OFS && wdata_i[1]) completion_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_q <= '0;
      err_q   <= 1'b0;
      case (offset_i)
        DB_DOORBELL_OFS:   if (!write_i) rdata_q <= {{(DATA_WIDTH-1){1'b0}}, doorbell_q};
        DB_COMPLETION_OFS: if (!write_i) rdata_q <= {{(DATA_WIDTH-1){1'b0}}, completion_q};
        // both flags
        DB_CLEAR_OFS: begin
          if (!write_i) rdata_q <= {{(DATA_WIDTH-2){1'b0}}, completion_q, doorbell_q};
        end
        default: err_q <= 1'b1;
      endcase
    end
  end

  assign rdata_o          = rdata_q;
  assign err_o            = err_q;
  assign doorbell_irq_o   = doorbell_q;
  assign completion_irq_o = completion_q;

endmodule

`default_nettype wire

//--- design/irq_edge_detect.sv
`timescale 1ns/1ps
`default_nettype none

module irq_edge_detect (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  input  wire logic level_i,
  output logic      pulse_o
);

  logic level_q;
  logic pulse_q;

  // Pulse one cycle after the level goes high
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      level_q <= 1'b0;
      pulse_q <= 1'b0;
    end else begin
      level_q <= level_i;
      pulse_q <= level_i && !level_q;
    end
  end

  assign pulse_o = pulse_q;

endmodule

`default_nettype wire

//--- design/cfg_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_subsystem_top import cfg_bus_pkg::*; #(
  parameter int unsigned MBOX_DEPTH = 8
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire logic                  host_req_valid_i,
  input  wire logic                  host_req_write_i,
  input  wire logic [ADDR_WIDTH-1:0] host_req_addr_i,
  input  wire logic [DATA_WIDTH-1:0] host_req_wdata_i,
  output logic                       host_req_ready_o,
  output logic                       host_resp_valid_o,
  output logic      [DATA_WIDTH-1:0] host_resp_rdata_o,
  output logic                       host_resp_err_o,
  input  wire logic                  cluster_req_valid_i,
  input  wire logic                  cluster_req_write_i,
  input  wire logic [ADDR_WIDTH-1:0] cluster_req_addr_i,
  input  wire logic [DATA_WIDTH-1:0] cluster_req_wdata_i,
  output logic                       cluster_req_ready_o,
  output logic                       cluster_resp_valid_o,
  output logic      [DATA_WIDTH-1:0] cluster_resp_rdata_o,
  output logic                       cluster_resp_err_o,
  output logic                       h2c_irq_o,
  output logic                       c2h_irq_o,
  output logic                       doorbell_irq_o,
  output logic                       completion_irq_o
);

  logic                  acc_valid, acc_write;
  logic [ADDR_WIDTH-1:0] acc_addr;
  logic [DATA_WIDTH-1:0] acc_wdata;
  logic                  rsp_valid, rsp_err;
  logic [DATA_WIDTH-1:0] rsp_rdata;
  logic                  h2c_sel, c2h_sel, db_sel;
  logic                  tgt_write;
  logic [OFS_WIDTH-1:0]  tgt_offset;
  logic [DATA_WIDTH-1:0] tgt_wdata;
  logic [DATA_WIDTH-1:0] h2c_rdata, c2h_rdata, db_rdata;
  logic                  h2c_err, c2h_err, db_err;
  logic                  c2h_level;

  cfg_bus_arbiter u_arbiter (
    .clk_i, .rst_n_i,
    .host_req_valid_i, .host_req_write_i, .host_req_addr_i, .host_req_wdata_i,
    .host_req_ready_o, .host_resp_valid_o, .host_resp_rdata_o, .host_resp_err_o,
    .cluster_req_valid_i, .cluster_req_write_i, .cluster_req_addr_i, .cluster_req_wdata_i,
    .cluster_req_ready_o, .cluster_resp_valid_o, .cluster_resp_rdata_o, .cluster_resp_err_o,
    .acc_valid_o (acc_valid), .acc_write_o (acc_write),
    .acc_addr_o  (acc_addr),  .acc_wdata_o (acc_wdata),
    .rsp_valid_i (rsp_valid), .rsp_rdata_i (rsp_rdata), .rsp_err_i (rsp_err)
  );

  cfg_addr_decoder u_decoder (
    .clk_i, .rst_n_i,
    .acc_valid_i (acc_valid), .acc_write_i (acc_write),
    .acc_addr_i  (acc_addr),  .acc_wdata_i (acc_wdata),
    .h2c_sel_o (h2c_sel), .c2h_sel_o (c2h_sel), .db_sel_o (db_sel),
    .tgt_write_o (tgt_write), .tgt_offset_o (tgt_offset), .tgt_wdata_o (tgt_wdata),
    .h2c_rdata_i (h2c_rdata), .h2c_err_i (h2c_err),
    .c2h_rdata_i (c2h_rdata), .c2h_err_i (c2h_err),
    .db_rdata_i  (db_rdata),  .db_err_i  (db_err),
    .rsp_valid_o (rsp_valid), .rsp_rdata_o (rsp_rdata), .rsp_err_o (rsp_err)
  );

  msg_mailbox #(.MBOX_DEPTH(MBOX_DEPTH)) u_h2c_mbox (
    .clk_i, .rst_n_i,
    .sel_i (h2c_sel), .write_i (tgt_write), .offset_i (tgt_offset), .wdata_i (tgt_wdata),
    .rdata_o (h2c_rdata), .err_o (h2c_err), .irq_o (h2c_irq_o)
  );

  msg_mailbox #(.MBOX_DEPTH(MBOX_DEPTH)) u_c2h_mbox (
    .clk_i, .rst_n_i,
    .sel_i (c2h_sel), .write_i (tgt_write), .offset_i (tgt_offset), .wdata_i (tgt_wdata),
    .rdata_o (c2h_rdata), .err_o (c2h_err), .irq_o (c2h_level)
  );

  doorbell_regs u_doorbell (
    .clk_i, .rst_n_i,
    .sel_i (db_sel), .write_i (tgt_write), .offset_i (tgt_offset), .wdata_i (tgt_wdata),
    .rdata_o (db_rdata), .err_o (db_err),
    .doorbell_irq_o, .completion_irq_o
  );

  // Host sees the cluster mailbox interrupt as an edge
  irq_edge_detect u_c2h_irq_edge (
    .clk_i, .rst_n_i,
    .level_i (c2h_level),
    .pulse_o (c2h_irq_o)
  );

endmodule

`default_nettype wire

//--- tb/cfg_bus_tasks.svh
// Expected mailbox contents, oldest word first
logic [31:0] h2c_model[$];
logic [31:0] c2h_model[$];

// All tasks start and end right after a rising clock edge
task automatic bus_access(input bit cluster, input bit write, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
  bit seen;
  if (cluster) begin
    cluster_req_valid <= 1'b1;
    cluster_req_write <= write;
    cluster_req_addr  <= addr;
    cluster_req_wdata <= wdata;
    cluster_reqs++;
  end else begin
    host_req_valid <= 1'b1;
    host_req_write <= write;
    host_req_addr  <= addr;
    host_req_wdata <= wdata;
    host_reqs++;
  end
  seen = 1'b0;
  while (!seen) begin
    @(posedge clk);
    seen = cluster ? cluster_req_ready : host_req_ready;
  end
  if (cluster) cluster_req_valid <= 1'b0;
  else host_req_valid <= 1'b0;
  seen = 1'b0;
  while (!seen) begin
    @(posedge clk);
    seen = cluster ? cluster_resp_valid : host_resp_valid;
  end
  rdata = cluster ? cluster_resp_rdata : host_resp_rdata;
  err   = cluster ? cluster_resp_err : host_resp_err;
endtask

task automatic check_access(input bit cluster, input bit write, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [31:0] exp_rdata,
                            input logic exp_err, input string what);
  logic [31:0] rdata;
  logic        err;
  bus_access(cluster, write, addr, wdata, rdata, err);
  assert (rdata === exp_rdata)
    else report_mismatch($sformatf("%s at %h: rdata %h, expected %h", what, addr, rdata,
                                   exp_rdata));
  assert (err === exp_err)
    else report_mismatch($sformatf("%s at %h: err %b, expected %b", what, addr, err, exp_err));
endtask

function automatic logic [31:0] mbox_base(input tgt_sel_e mbox);
  return (mbox == TGT_C2H) ? C2H_MBOX_BASE : H2C_MBOX_BASE;
endfunction

function automatic int model_level(input tgt_sel_e mbox);
  return (mbox == TGT_C2H) ? c2h_model.size() : h2c_model.size();
endfunction

// A push into a full mailbox is dropped
task automatic push_word(input bit cluster, input tgt_sel_e mbox, input logic [31:0] data);
  bit full;
  full = (model_level(mbox) == MBOX_DEPTH);
  if (!full && mbox == TGT_C2H) c2h_model.push_back(data);
  else if (!full) h2c_model.push_back(data);
  check_access(cluster, 1'b1, mbox_base(mbox) + MBOX_DATA_OFS, data, 32'h0, full, "push");
endtask

task automatic pop_word(input bit cluster, input tgt_sel_e mbox);
  logic [31:0] exp;
  bit          empty;
  empty = (model_level(mbox) == 0);
  exp   = 32'h0;
  if (!empty && mbox == TGT_C2H) exp = c2h_model.pop_front();
  else if (!empty) exp = h2c_model.pop_front();
  check_access(cluster, 1'b0, mbox_base(mbox) + MBOX_DATA_OFS, 32'h0, exp, empty, "pop");
endtask

task automatic check_status(input bit cluster, input tgt_sel_e mbox);
  int          level;
  logic [31:0] exp;
  level  = model_level(mbox);
  exp    = 32'(level) << 8;
  exp[1] = (level == MBOX_DEPTH);
  exp[0] = (level == 0);
  check_access(cluster, 1'b0, mbox_base(mbox) + MBOX_STATUS_OFS, 32'h0, exp, 1'b0, "status");
endtask

//--- tb/tb_cfg_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cfg_subsystem import cfg_bus_pkg::*; ();

  localparam int unsigned MBOX_DEPTH = 8;
  localparam int unsigned MAX_CYCLES = 4000;

  logic        clk;
  logic        rst_n;
  logic        host_req_valid, host_req_write, host_req_ready;
  logic [31:0] host_req_addr, host_req_wdata, host_resp_rdata;
  logic        host_resp_valid, host_resp_err;
  logic        cluster_req_valid, cluster_req_write, cluster_req_ready;
  logic [31:0] cluster_req_addr, cluster_req_wdata, cluster_resp_rdata;
  logic        cluster_resp_valid, cluster_resp_err;
  logic        h2c_irq, c2h_irq, doorbell_irq, completion_irq;

  integer      seed = 32'h3dad;
  int unsigned cycles, c2h_pulses;
  int unsigned host_reqs, cluster_reqs, host_grants, cluster_grants;
  // One entry per grant with 1 for cluster
  bit          grant_log[$];

  cfg_subsystem_top #(.MBOX_DEPTH(MBOX_DEPTH)) u_dut (
    .clk_i (clk), .rst_n_i (rst_n),
    .host_req_valid_i (host_req_valid), .host_req_write_i (host_req_write),
    .host_req_addr_i (host_req_addr), .host_req_wdata_i (host_req_wdata),
    .host_req_ready_o (host_req_ready), .host_resp_valid_o (host_resp_valid),
    .host_resp_rdata_o (host_resp_rdata), .host_resp_err_o (host_resp_err),
    .cluster_req_valid_i (cluster_req_valid), .cluster_req_write_i (cluster_req_write),
    .cluster_req_addr_i (cluster_req_addr), .cluster_req_wdata_i (cluster_req_wdata),
    .cluster_req_ready_o (cluster_req_ready), .cluster_resp_valid_o (cluster_resp_valid),
    .cluster_resp_rdata_o (cluster_resp_rdata), .cluster_resp_err_o (cluster_resp_err),
    .h2c_irq_o (h2c_irq), .c2h_irq_o (c2h_irq),
    .doorbell_irq_o (doorbell_irq), .completion_irq_o (completion_irq)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string msg);
    stop_on_error($sformatf("MISMATCH at %0t: %s", $time, msg));
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    assert (got === exp)
      else report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
  endtask

  `include "cfg_bus_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) stop_on_error("Timeout: the tests did not finish in time");
    if (host_req_ready) begin
      host_grants++;
      grant_log.push_back(1'b0);
    end
    if (cluster_req_ready) begin
      cluster_grants++;
      grant_log.push_back(1'b1);
    end
    if (c2h_irq) c2h_pulses++;
  end

  // Bus timing rules
  a_host_resp: assert property (@(posedge clk) disable iff (!rst_n)
      host_req_ready |=> host_resp_valid)
    else stop_on_error("Host response did not follow its grant by one cycle");
  a_host_orphan: assert property (@(posedge clk) disable iff (!rst_n)
      host_resp_valid |-> $past(host_req_ready))
    else stop_on_error("Host got a response without a granted request");
  a_cluster_resp: assert property (@(posedge clk) disable iff (!rst_n)
      cluster_req_ready |=> cluster_resp_valid)
    else stop_on_error("Cluster response did not follow its grant by one cycle");
  a_cluster_orphan: assert property (@(posedge clk) disable iff (!rst_n)
      cluster_resp_valid |-> $past(cluster_req_ready))
    else stop_on_error("Cluster got a response without a granted request");
  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
      !(host_req_ready && cluster_req_ready) &&
      (!host_req_ready || host_req_valid) && (!cluster_req_ready || cluster_req_valid))
    else stop_on_error("A grant was given to a master that was not requesting alone");
  a_c2h_pulse: assert property (@(posedge clk) disable iff (!rst_n) c2h_irq |=> !c2h_irq)
    else stop_on_error("Cluster to host interrupt stayed high for more than one cycle");

  initial begin
    logic [31:0] word_a;
    logic [31:0] word_b;
    int unsigned first;
    {host_req_valid, host_req_write, host_req_addr, host_req_wdata} = '0;
    {cluster_req_valid, cluster_req_write, cluster_req_addr, cluster_req_wdata} = '0;
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Host to cluster traffic in order
    for (int i = 0; i < 5; i++) begin
      push_word(1'b0, TGT_H2C, $random(seed));
      check_status(1'b0, TGT_H2C);
    end
    while (h2c_model.size() > 0) begin
      pop_word(1'b1, TGT_H2C);
      check_status(1'b1, TGT_H2C);
    end

    // Overflow and underflow
    for (int i = 0; i < MBOX_DEPTH; i++) push_word(1'b0, TGT_H2C, $random(seed));
    check_status(1'b0, TGT_H2C);
    push_word(1'b0, TGT_H2C, 32'hdead_beef);
    check_status(1'b0, TGT_H2C);
    for (int i = 0; i < MBOX_DEPTH; i++) pop_word(1'b1, TGT_H2C);
    pop_word(1'b1, TGT_H2C);
    check_status(1'b1, TGT_H2C);

    // Unmapped addresses and a bad register offset
    check_access(1'b0, 1'b0, DOORBELL_BASE + REGION_SIZE, 32'h0, 32'h0, 1'b1, "unmapped read");
    check_access(1'b1, 1'b1, 32'h0, $random(seed), 32'h0, 1'b1, "unmapped write");
    check_access(1'b0, 1'b0, H2C_MBOX_BASE - 4, 32'h0, 32'h0, 1'b1, "unmapped read");
    check_access(1'b1, 1'b0, C2H_MBOX_BASE + 32'h10, 32'h0, 32'h0, 1'b1, "bad offset");

    // Mailbox interrupts
    check_access(1'b0, 1'b1, H2C_MBOX_BASE + MBOX_THRESH_OFS, 32'd2, 32'h0, 1'b0, "thresh");
    check_access(1'b0, 1'b1, H2C_MBOX_BASE + MBOX_IRQEN_OFS, 32'd1, 32'h0, 1'b0, "irq enable");
    check_access(1'b1, 1'b0, H2C_MBOX_BASE + MBOX_THRESH_OFS, 32'h0, 32'd2, 1'b0, "thresh");
    for (int i = 0; i < 3; i++) begin
      push_word(1'b0, TGT_H2C, $random(seed));
      check_level("h2c_irq_o", h2c_irq, h2c_model.size() > 2);
    end
    pop_word(1'b1, TGT_H2C);
    check_level("h2c_irq_o", h2c_irq, 1'b0);
    while (h2c_model.size() > 0) pop_word(1'b1, TGT_H2C);
    check_access(1'b1, 1'b1, C2H_MBOX_BASE + MBOX_IRQEN_OFS, 32'd1, 32'h0, 1'b0, "irq enable");
    push_word(1'b1, TGT_C2H, $random(seed));
    push_word(1'b1, TGT_C2H, $random(seed));
    while (c2h_model.size() > 0) pop_word(1'b0, TGT_C2H);
    push_word(1'b1, TGT_C2H, $random(seed));
    pop_word(1'b0, TGT_C2H);
    assert (c2h_pulses == 2)
      else report_mismatch($sformatf("%0d c2h_irq_o pulses, expected 2", c2h_pulses));

    // Doorbell and completion flags
    check_access(1'b1, 1'b1, DOORBELL_BASE + DB_DOORBELL_OFS, 32'd1, 32'h0, 1'b0, "ring");
    check_level("doorbell_irq_o", doorbell_irq, 1'b1);
    check_level("completion_irq_o", completion_irq, 1'b0);
    check_access(1'b0, 1'b0, DOORBELL_BASE + DB_DOORBELL_OFS, 32'h0, 32'd1, 1'b0, "doorbell");
    check_access(1'b0, 1'b1, DOORBELL_BASE + DB_COMPLETION_OFS, 32'd1, 32'h0, 1'b0, "done");
    check_level("completion_irq_o", completion_irq, 1'b1);
    check_access(1'b1, 1'b0, DOORBELL_BASE + DB_CLEAR_OFS, 32'h0, 32'd3, 1'b0, "flags");
    check_access(1'b0, 1'b1, DOORBELL_BASE + DB_CLEAR_OFS, 32'd1, 32'h0, 1'b0, "clear");
    check_level("doorbell_irq_o", doorbell_irq, 1'b0);
    check_level("completion_irq_o", completion_irq, 1'b1);
    check_access(1'b1, 1'b0, DOORBELL_BASE + DB_COMPLETION_OFS, 32'h0, 32'd1, 1'b0, "done");
    check_access(1'b0, 1'b1, DOORBELL_BASE + DB_CLEAR_OFS, 32'd2, 32'h0, 1'b0, "clear");
    check_level("completion_irq_o", completion_irq, 1'b0);
    check_access(1'b0, 1'b0, DOORBELL_BASE + DB_CLEAR_OFS, 32'h0, 32'h0, 1'b0, "flags");

    // Both masters request together and each tie goes to the master not granted last
    first = grant_log.size();
    for (int r = 0; r < 4; r++) begin
      word_a = $random(seed);
      word_b = $random(seed);
      fork
        push_word(1'b0, TGT_H2C, word_a);
        push_word(1'b1, TGT_C2H, word_b);
      join
    end
    // A lone cluster access makes host the next tie winner
    check_status(1'b1, TGT_C2H);
    for (int r = 0; r < 4; r++) begin
      fork
        pop_word(1'b0, TGT_C2H);
        pop_word(1'b1, TGT_H2C);
      join
    end
    for (int i = first; i < grant_log.size(); i++) begin
      assert (grant_log[i] != grant_log[i-1])
        else report_mismatch($sformatf("grant %0d went to the same master twice", i));
    end
    assert (grant_log.size() - first == 17 && host_grants == host_reqs &&
            cluster_grants == cluster_reqs)
      else report_mismatch($sformatf("grants %0d/%0d for requests %0d/%0d", host_grants,
                                     cluster_grants, host_reqs, cluster_reqs));

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+tb
design/cfg_bus_pkg.sv
design/cfg_bus_arbiter.sv
design/cfg_addr_decoder.sv
design/msg_mailbox.sv
design/doorbell_regs.sv
design/irq_edge_detect.sv
design/cfg_subsystem_top.sv
tb/tb_cfg_subsystem.sv

//--- Bender.yml
package:
  name: cfg_subsystem

sources:
  - design/cfg_bus_pkg.sv
  - design/cfg_bus_arbiter.sv
  - design/cfg_addr_decoder.sv
  - design/msg_mailbox.sv
  - design/doorbell_regs.sv
  - design/irq_edge_detect.sv
  - design/cfg_subsystem_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_cfg_subsystem.sv
